/* dv/tb_ooo_backend.sv */
`timescale 1ns/1ps

module tb_ooo_backend;

  localparam int NUM_INSTR        = 300;
  localparam int CYCLES_PER_INSTR = 20;
  localparam int EXP_DEPTH        = 512;

  logic                     clk_i;
  logic                     reset_i;
  logic                     instr_valid_i;
  ooo_backend_pkg::instr_t  instr_i;
  logic                     instr_ready_o;
  logic                     commit_valid_o;
  ooo_backend_pkg::commit_t commit_o;

  // expected commits written on accept and read on commit
  ooo_backend_pkg::commit_t exp_mem [EXP_DEPTH];
  ooo_backend_pkg::commit_t exp_front;
  logic [8:0]               wr_ptr;
  logic [8:0]               rd_ptr;
  ooo_backend_pkg::xdata_t  model_regs [ooo_backend_pkg::REG_NUM];
  logic [31:0]              lfsr_state;

  ooo_backend u_dut (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .instr_ready_o (instr_ready_o),
    .commit_valid_o(commit_valid_o),
    .commit_o      (commit_o)
  );

  initial begin
    clk_i = 1'b0;
    forever begin
      #4 clk_i = ~clk_i;
    end
  end

  // --------------------------------------------------------------------------
  // helpers
  // --------------------------------------------------------------------------

  task automatic fail_with(input string msg);
    $display("%s", msg);
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    fail_with($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  // fibonacci lfsr on x^32 + x^22 + x^2 + x + 1
  // one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] bits;
    logic        fb;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      bits       = {bits[30:0], fb};
    end
    return bits;
  endfunction

  // architectural result from the opcode rules
  function automatic ooo_backend_pkg::xdata_t model_result(
    input ooo_backend_pkg::instr_t ins
  );
    ooo_backend_pkg::xdata_t a;
    ooo_backend_pkg::xdata_t b;
    ooo_backend_pkg::xdata_t res;
    a = model_regs[ins.rs1];
    b = model_regs[ins.rs2];
    case (ins.opcode)
      ooo_backend_pkg::OP_ADD:  res = a + b;
      ooo_backend_pkg::OP_SUB:  res = a - b;
      ooo_backend_pkg::OP_AND:  res = a & b;
      ooo_backend_pkg::OP_OR:   res = a | b;
      ooo_backend_pkg::OP_XOR:  res = a ^ b;
      ooo_backend_pkg::OP_SLL:  res = a << b[4:0];
      ooo_backend_pkg::OP_ADDI: res = a + ins.imm;
      // low 32 bits of the product
      ooo_backend_pkg::OP_MUL:  res = a * b;
      default:                  res = '0;
    endcase
    return res;
  endfunction

  function automatic ooo_backend_pkg::instr_t next_instr(
    input ooo_backend_pkg::reg_idx_t prev_rd
  );
    ooo_backend_pkg::instr_t ins;
    logic [3:0]              op_sel;
    op_sel = 4'(rand_bits(4));
    // multiply drawn 5 times in 16
    ins.opcode = (op_sel >= 4'd12) ? ooo_backend_pkg::OP_MUL
                                   : ooo_backend_pkg::opcode_e'(op_sel[2:0]);
    ins.rd  = ooo_backend_pkg::reg_idx_t'(rand_bits(3) % 6);
    // half the time chain onto the previous result
    ins.rs1 = rand_bits(1) ? prev_rd : ooo_backend_pkg::reg_idx_t'(rand_bits(3) % 6);
    ins.rs2 = rand_bits(1) ? prev_rd : ooo_backend_pkg::reg_idx_t'(rand_bits(3) % 6);
    ins.imm = rand_bits(32);
    return ins;
  endfunction

  // starts at a falling edge and returns on the one after the handshake
  task automatic send_instr(input ooo_backend_pkg::instr_t ins);
    logic [8:0] target;
    target        = wr_ptr + 9'd1;
    instr_valid_i = 1'b1;
    instr_i       = ins;
    while (wr_ptr != target) begin
      @(negedge clk_i);
    end
    instr_valid_i = 1'b0;
  endtask

  // --------------------------------------------------------------------------
  // reference model in acceptance order
  // --------------------------------------------------------------------------

  assign exp_front = exp_mem[rd_ptr];

  always @(posedge clk_i) begin
    ooo_backend_pkg::xdata_t res;
    if (reset_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      for (int r = 0; r < ooo_backend_pkg::REG_NUM; r++) begin
        model_regs[r] = '0;
      end
    end else begin
      if (commit_valid_o) begin
        rd_ptr <= rd_ptr + 9'd1;
      end
      if (instr_valid_i && instr_ready_o) begin
        res = model_result(instr_i);
        exp_mem[wr_ptr] <= '{tag: wr_ptr[ooo_backend_pkg::ROB_IDX_LEN-1:0],
                             rd: instr_i.rd, value: res};
        // x0 stays zero
        if (instr_i.rd != '0) begin
          model_regs[instr_i.rd] = res;
        end
        wr_ptr <= wr_ptr + 9'd1;
      end
    end
  end

  // --------------------------------------------------------------------------
  // checks
  // --------------------------------------------------------------------------

  reset_quiet: assert property (@(posedge clk_i) $past(reset_i) |-> !commit_valid_o)
    else report_mismatch("commit_valid_o", 32'($sampled(commit_valid_o)), 32'h0);

  commit_outstanding: assert property (@(posedge clk_i) disable iff (reset_i)
      commit_valid_o |-> (rd_ptr < wr_ptr))
    else fail_with("commit seen with no accepted instruction waiting");

  commit_rd_match: assert property (@(posedge clk_i) disable iff (reset_i)
      commit_valid_o |-> (commit_o.rd == exp_front.rd))
    else report_mismatch("commit_o.rd", 32'($sampled(commit_o.rd)),
                         32'($sampled(exp_front.rd)));

  commit_value_match: assert property (@(posedge clk_i) disable iff (reset_i)
      commit_valid_o |-> (commit_o.value == exp_front.value))
    else report_mismatch("commit_o.value", $sampled(commit_o.value),
                         $sampled(exp_front.value));

  // tags run 0, 1, 2 ... modulo rob depth
  commit_tag_order: assert property (@(posedge clk_i) disable iff (reset_i)
      commit_valid_o |-> (commit_o.tag == exp_front.tag))
    else report_mismatch("commit_o.tag", 32'($sampled(commit_o.tag)),
                         32'($sampled(exp_front.tag)));

  // --------------------------------------------------------------------------
  // stimulus and watchdog
  // --------------------------------------------------------------------------

  initial begin
    ooo_backend_pkg::instr_t   ins;
    ooo_backend_pkg::reg_idx_t prev_rd;
    lfsr_state    = 32'heca;
    reset_i       = 1'b1;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    prev_rd       = '0;
    repeat (3) @(negedge clk_i);
    reset_i = 1'b0;
    for (int n = 0; n < NUM_INSTR; n++) begin
      ins = next_instr(prev_rd);
      send_instr(ins);
      prev_rd = ins.rd;
      // idle gap one time in four
      if (rand_bits(2) == 32'd0) begin
        @(negedge clk_i);
      end
    end
    while (rd_ptr != wr_ptr) begin
      @(negedge clk_i);
    end
    // bus stays quiet once everything has committed
    repeat (20) @(negedge clk_i);
    if (rd_ptr != wr_ptr) begin
      report_mismatch("commit count", 32'(rd_ptr), 32'(wr_ptr));
    end else begin
      $display("Testbench passed");
      $finish;
    end
  end

  initial begin
    repeat (NUM_INSTR * CYCLES_PER_INSTR) @(posedge clk_i);
    fail_with("watchdog expired before all instructions committed");
  end

endmodule

/* ooo_backend.f */
verilog/ooo_backend_pkg.sv
verilog/issue_stage.sv
verilog/reg_state.sv
verilog/alu_unit.sv
verilog/mul_unit.sv
verilog/cdb_arbiter.sv
verilog/commit_stage.sv
verilog/ooo_backend.sv
dv/tb_ooo_backend.sv

/* run_sim.sh */
#!/usr/bin/env bash
# compile and run the ooo_backend testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_ooo_backend \
  -f ooo_backend.f -Mdir obj_dir
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator compile failed with status $status"
  exit "$status"
fi

./obj_dir/Vtb_ooo_backend
status=$?
if [ "$status" -ne 0 ]; then
  echo "simulation failed with status $status"
  exit "$status"
fi
exit 0

/* verilog/alu_unit.sv */
`timescale 1ns/1ps

module alu_unit (
  input  logic                        clk_i,
  input  logic                        reset_i,

  // from issue
  input  logic                        valid_i,
  output logic                        ready_o,
  input  ooo_backend_pkg::eu_req_t    req_i,

  // to the cdb arbiter
  input  logic                        grant_i,
  output logic                        valid_o,
  output ooo_backend_pkg::cdb_t       result_o
);

  ooo_backend_pkg::xdata_t alu_res;
  ooo_backend_pkg::cdb_t   result_q;
  logic                    valid_q;

  // result slot frees up when empty or leaving this cycle
  assign ready_o = ~valid_q | grant_i;

  always_comb begin
    case (req_i.opcode)
      ooo_backend_pkg::OP_ADD:  alu_res = req_i.a + req_i.b;
      ooo_backend_pkg::OP_SUB:  alu_res = req_i.a - req_i.b;
      ooo_backend_pkg::OP_AND:  alu_res = req_i.a & req_i.b;
      ooo_backend_pkg::OP_OR:   alu_res = req_i.a | req_i.b;
      ooo_backend_pkg::OP_XOR:  alu_res = req_i.a ^ req_i.b;
      // shift amount from low 5 bits only
      ooo_backend_pkg::OP_SLL:  alu_res = req_i.a << req_i.b[4:0];
      ooo_backend_pkg::OP_ADDI: alu_res = req_i.a + req_i.b;
      default:                  alu_res = '0;
    endcase
  end

  // valid flag, held until the bus takes it
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q <= 1'b0;
    end else if (valid_i && ready_o) begin
      valid_q <= 1'b1;
    end else if (grant_i) begin
      valid_q <= 1'b0;
    end
  end

  // result payload
  always_ff @(posedge clk_i) begin
    if (valid_i && ready_o) begin
      result_q <= '{tag: req_i.tag, value: alu_res};
    end
  end

  assign valid_o  = valid_q;
  assign result_o = result_q;

endmodule

/* verilog/cdb_arbiter.sv */
`timescale 1ns/1ps

module cdb_arbiter (
  // alu side, held until granted
  input  logic                        alu_valid_i,
  input  ooo_backend_pkg::cdb_t       alu_result_i,

  // multiplier side, always taken
  input  logic                        mul_valid_i,
  input  ooo_backend_pkg::cdb_t       mul_result_i,

  output logic                        alu_grant_o,
  output logic                        cdb_valid_o,
  output ooo_backend_pkg::cdb_t       cdb_o
);

  // fixed priority, multiplier pipeline has no stall path
  assign alu_grant_o = alu_valid_i & ~mul_valid_i;

  // one broadcast per cycle at most
  assign cdb_valid_o = mul_valid_i | alu_valid_i;

  // mux follows the same priority
  assign cdb_o = mul_valid_i ? mul_result_i : alu_result_i;

endmodule

/* verilog/commit_stage.sv */
`timescale 1ns/1ps

module commit_stage (
  input  logic                        clk_i,
  input  logic                        reset_i,

  // allocation from issue
  input  logic                        alloc_valid_i,
  input  ooo_backend_pkg::reg_idx_t   alloc_rd_i,
  output logic                        rob_full_o,
  output ooo_backend_pkg::rob_idx_t   rob_tail_o,

  // results from the cdb
  input  logic                        cdb_valid_i,
  input  ooo_backend_pkg::cdb_t       cdb_i,

  // retirement, registered
  output logic                        commit_valid_o,
  output ooo_backend_pkg::commit_t    commit_o
);

  localparam int D = ooo_backend_pkg::ROB_DEPTH;

  typedef logic [ooo_backend_pkg::ROB_IDX_LEN:0] rob_cnt_t;

  // rob payload
  typedef struct packed {
    ooo_backend_pkg::reg_idx_t rd;
    ooo_backend_pkg::xdata_t   value;
  } rob_entry_t;

  rob_entry_t                rob_q [D];
  logic [D-1:0]              done_q;
  ooo_backend_pkg::rob_idx_t head_q;
  ooo_backend_pkg::rob_idx_t tail_q;
  rob_cnt_t                  count_q;
  logic                      retire;
  logic                      commit_valid_q;
  ooo_backend_pkg::commit_t  commit_q;

  // head leaves once its result is in
  assign retire     = (count_q != '0) && done_q[head_q];
  assign rob_full_o = (count_q == rob_cnt_t'(D));
  assign rob_tail_o = tail_q;

  // --------------------------------------------------------------------------
  // pointers, count and done bits
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
      done_q  <= '0;
    end else begin
      if (cdb_valid_i) begin
        done_q[cdb_i.tag] <= 1'b1;
      end
      if (retire) begin
        done_q[head_q] <= 1'b0;
        head_q         <= head_q + 1'b1;
      end
      // fresh slot starts not done
      if (alloc_valid_i) begin
        done_q[tail_q] <= 1'b0;
        tail_q         <= tail_q + 1'b1;
      end
      case ({alloc_valid_i, retire})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // entry payload
  always_ff @(posedge clk_i) begin
    if (alloc_valid_i) begin
      rob_q[tail_q].rd <= alloc_rd_i;
    end
    if (cdb_valid_i) begin
      rob_q[cdb_i.tag].value <= cdb_i.value;
    end
  end

  // retirement strobe
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      commit_valid_q <= 1'b0;
    end else begin
      commit_valid_q <= retire;
    end
  end

  always_ff @(posedge clk_i) begin
    if (retire) begin
      commit_q <= '{tag: head_q, rd: rob_q[head_q].rd, value: rob_q[head_q].value};
    end
  end

  assign commit_valid_o = commit_valid_q;
  assign commit_o       = commit_q;

endmodule

/* verilog/issue_stage.sv */
`timescale 1ns/1ps

module issue_stage (
  // decoded instruction in
  input  logic                        instr_valid_i,
  input  ooo_backend_pkg::instr_t     instr_i,
  output logic                        instr_ready_o,

  // register file and status lookup
  output ooo_backend_pkg::reg_idx_t   rs1_idx_o,
  output ooo_backend_pkg::reg_idx_t   rs2_idx_o,
  input  ooo_backend_pkg::xdata_t     rs1_value_i,
  input  ooo_backend_pkg::xdata_t     rs2_value_i,
  input  logic                        rs1_busy_i,
  input  logic                        rs2_busy_i,

  // rob and register status allocation
  output logic                        alloc_valid_o,
  output ooo_backend_pkg::reg_idx_t   alloc_rd_o,
  input  logic                        rob_full_i,
  input  ooo_backend_pkg::rob_idx_t   rob_tail_i,

  // dispatch to the execution units
  output logic                        alu_valid_o,
  input  logic                        alu_ready_i,
  output logic                        mul_valid_o,
  output ooo_backend_pkg::eu_req_t    eu_req_o
);

  logic is_mul;
  logic uses_rs2;
  logic src_busy;
  logic unit_ready;
  logic accept;

  // unit select and operand b source
  assign is_mul   = (instr_i.opcode == ooo_backend_pkg::OP_MUL);
  assign uses_rs2 = (instr_i.opcode != ooo_backend_pkg::OP_ADDI);

  // sources straight from the instruction
  assign rs1_idx_o = instr_i.rs1;
  assign rs2_idx_o = instr_i.rs2;

  // no forwarding, so any busy source stalls until its owner commits
  assign src_busy = rs1_busy_i | (uses_rs2 & rs2_busy_i);

  // multiplier pipeline never stalls
  assign unit_ready = is_mul ? 1'b1 : alu_ready_i;

  assign instr_ready_o = ~src_busy & ~rob_full_i & unit_ready;
  assign accept        = instr_valid_i & instr_ready_o;

  // allocation strobes only on handshake
  assign alloc_valid_o = accept;
  assign alloc_rd_o    = instr_i.rd;

  assign alu_valid_o = accept & ~is_mul;
  assign mul_valid_o = accept & is_mul;

  // shared request bus, tag is the rob slot being allocated
  assign eu_req_o.opcode = instr_i.opcode;
  assign eu_req_o.a      = rs1_value_i;
  assign eu_req_o.b      = uses_rs2 ? rs2_value_i : instr_i.imm;
  assign eu_req_o.tag    = rob_tail_i;

endmodule

/* verilog/mul_unit.sv */
`timescale 1ns/1ps

module mul_unit (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic                        valid_i,
  input  ooo_backend_pkg::eu_req_t    req_i,
  output logic                        valid_o,
  output ooo_backend_pkg::cdb_t       result_o
);

  localparam int S = ooo_backend_pkg::MUL_STAGES;

  ooo_backend_pkg::xdata_t product;
  ooo_backend_pkg::cdb_t   stage_q [S];
  logic [S-1:0]            valid_q;

  // low half of the product only
  assign product = req_i.a * req_i.b;

  // valid bits shift with the data, one item per stage
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q <= '0;
    end else begin
      valid_q <= {valid_q[S-2:0], valid_i};
    end
  end

  // tag travels next to the value
  always_ff @(posedge clk_i) begin
    stage_q[0] <= '{tag: req_i.tag, value: product};
    for (int s = 1; s < S; s++) begin
      stage_q[s] <= stage_q[s-1];
    end
  end

  assign valid_o  = valid_q[S-1];
  assign result_o = stage_q[S-1];

endmodule

/* verilog/ooo_backend.sv */
`timescale 1ns/1ps

module ooo_backend (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic                        instr_valid_i,
  input  ooo_backend_pkg::instr_t     instr_i,
  output logic                        instr_ready_o,
  output logic                        commit_valid_o,
  output ooo_backend_pkg::commit_t    commit_o
);

  // --------------------------------------------------------------------------
  // internal wires
  // --------------------------------------------------------------------------

  // issue <-> register state
  ooo_backend_pkg::reg_idx_t rs1_idx;
  ooo_backend_pkg::reg_idx_t rs2_idx;
  ooo_backend_pkg::xdata_t   rs1_value;
  ooo_backend_pkg::xdata_t   rs2_value;
  logic                      rs1_busy;
  logic                      rs2_busy;

  // issue -> rob and status allocation
  logic                      alloc_valid;
  ooo_backend_pkg::reg_idx_t alloc_rd;
  logic                      rob_full;
  ooo_backend_pkg::rob_idx_t rob_tail;

  // issue -> units
  logic                      alu_valid;
  logic                      alu_ready;
  logic                      mul_valid;
  ooo_backend_pkg::eu_req_t  eu_req;

  // units -> cdb -> rob
  logic                      alu_res_valid;
  ooo_backend_pkg::cdb_t     alu_res;
  logic                      alu_grant;
  logic                      mul_res_valid;
  ooo_backend_pkg::cdb_t     mul_res;
  logic                      cdb_valid;
  ooo_backend_pkg::cdb_t     cdb;

  // --------------------------------------------------------------------------
  // issue, register state and execution units
  // --------------------------------------------------------------------------
  issue_stage u_issue_stage (
    .instr_valid_i(instr_valid_i),
    .instr_i      (instr_i),
    .instr_ready_o(instr_ready_o),
    .rs1_idx_o    (rs1_idx),
    .rs2_idx_o    (rs2_idx),
    .rs1_value_i  (rs1_value),
    .rs2_value_i  (rs2_value),
    .rs1_busy_i   (rs1_busy),
    .rs2_busy_i   (rs2_busy),
    .alloc_valid_o(alloc_valid),
    .alloc_rd_o   (alloc_rd),
    .rob_full_i   (rob_full),
    .rob_tail_i   (rob_tail),
    .alu_valid_o  (alu_valid),
    .alu_ready_i  (alu_ready),
    .mul_valid_o  (mul_valid),
    .eu_req_o     (eu_req)
  );

  // writeback comes from the same registered commit as the output
  reg_state u_reg_state (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .rs1_idx_i    (rs1_idx),
    .rs2_idx_i    (rs2_idx),
    .rs1_value_o  (rs1_value),
    .rs2_value_o  (rs2_value),
    .rs1_busy_o   (rs1_busy),
    .rs2_busy_o   (rs2_busy),
    .alloc_valid_i(alloc_valid),
    .alloc_rd_i   (alloc_rd),
    .alloc_tag_i  (rob_tail),
    .wb_valid_i   (commit_valid_o),
    .wb_i         (commit_o)
  );

  alu_unit u_alu_unit (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .valid_i (alu_valid),
    .ready_o (alu_ready),
    .req_i   (eu_req),
    .grant_i (alu_grant),
    .valid_o (alu_res_valid),
    .result_o(alu_res)
  );

  mul_unit u_mul_unit (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .valid_i (mul_valid),
    .req_i   (eu_req),
    .valid_o (mul_res_valid),
    .result_o(mul_res)
  );

  // --------------------------------------------------------------------------
  // cdb and commit
  // --------------------------------------------------------------------------
  cdb_arbiter u_cdb_arbiter (
    .alu_valid_i (alu_res_valid),
    .alu_result_i(alu_res),
    .mul_valid_i (mul_res_valid),
    .mul_result_i(mul_res),
    .alu_grant_o (alu_grant),
    .cdb_valid_o (cdb_valid),
    .cdb_o       (cdb)
  );

  commit_stage u_commit_stage (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .alloc_valid_i (alloc_valid),
    .alloc_rd_i    (alloc_rd),
    .rob_full_o    (rob_full),
    .rob_tail_o    (rob_tail),
    .cdb_valid_i   (cdb_valid),
    .cdb_i         (cdb),
    .commit_valid_o(commit_valid_o),
    .commit_o      (commit_o)
  );

endmodule

/* verilog/ooo_backend_pkg.sv */
package ooo_backend_pkg;

  // --------------------------------------------------------------------------
  // widths and sizes
  // --------------------------------------------------------------------------

  // integer datapath width
  localparam int XLEN = 32;
  // architectural integer registers
  localparam int REG_NUM = 32;
  localparam int REG_IDX_LEN = 5;
  // reorder buffer, depth is a power of two so pointers wrap on their own
  localparam int ROB_DEPTH = 8;
  localparam int ROB_IDX_LEN = 3;
  // multiplier pipeline depth
  localparam int MUL_STAGES = 3;

  typedef logic [XLEN-1:0] xdata_t;
  typedef logic [REG_IDX_LEN-1:0] reg_idx_t;
  typedef logic [ROB_IDX_LEN-1:0] rob_idx_t;

  // --------------------------------------------------------------------------
  // opcodes and shared structs
  // --------------------------------------------------------------------------

  // seven alu ops plus the multiply
  typedef enum logic [2:0] {
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_SLL,
    OP_ADDI,
    OP_MUL
  } opcode_e;

  // decoded instruction from the front end
  typedef struct packed {
    opcode_e  opcode;
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    xdata_t   imm;
  } instr_t;

  // request to an execution unit, b is already rs2 or imm
  typedef struct packed {
    opcode_e  opcode;
    xdata_t   a;
    xdata_t   b;
    rob_idx_t tag;
  } eu_req_t;

  // result on the common data bus
  typedef struct packed {
    rob_idx_t tag;
    xdata_t   value;
  } cdb_t;

  // retired result, goes to the register file and out of the core
  typedef struct packed {
    rob_idx_t tag;
    reg_idx_t rd;
    xdata_t   value;
  } commit_t;

endpackage

/* verilog/reg_state.sv */
`timescale 1ns/1ps

module reg_state (
  input  logic                        clk_i,
  input  logic                        reset_i,

  // issue lookup
  input  ooo_backend_pkg::reg_idx_t   rs1_idx_i,
  input  ooo_backend_pkg::reg_idx_t   rs2_idx_i,
  output ooo_backend_pkg::xdata_t     rs1_value_o,
  output ooo_backend_pkg::xdata_t     rs2_value_o,
  output logic                        rs1_busy_o,
  output logic                        rs2_busy_o,

  // issue allocation
  input  logic                        alloc_valid_i,
  input  ooo_backend_pkg::reg_idx_t   alloc_rd_i,
  input  ooo_backend_pkg::rob_idx_t   alloc_tag_i,

  // commit writeback
  input  logic                        wb_valid_i,
  input  ooo_backend_pkg::commit_t    wb_i
);

  ooo_backend_pkg::xdata_t   regs_q  [ooo_backend_pkg::REG_NUM];
  ooo_backend_pkg::rob_idx_t owner_q [ooo_backend_pkg::REG_NUM];
  logic [ooo_backend_pkg::REG_NUM-1:0] busy_q;

  // x0 hardwired to zero
  assign rs1_value_o = (rs1_idx_i == '0) ? '0 : regs_q[rs1_idx_i];
  assign rs2_value_o = (rs2_idx_i == '0) ? '0 : regs_q[rs2_idx_i];

  // busy_q[0] is never set
  assign rs1_busy_o = busy_q[rs1_idx_i];
  assign rs2_busy_o = busy_q[rs2_idx_i];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_q <= '0;
      for (int i = 0; i < ooo_backend_pkg::REG_NUM; i++) begin
        regs_q[i]  <= '0;
        owner_q[i] <= '0;
      end
    end else begin
      if (wb_valid_i && (wb_i.rd != '0)) begin
        regs_q[wb_i.rd] <= wb_i.value;
        // a younger writer keeps the register busy
        if (owner_q[wb_i.rd] == wb_i.tag) begin
          busy_q[wb_i.rd] <= 1'b0;
        end
      end
      // last assignment, so a new owner beats the clear
      if (alloc_valid_i && (alloc_rd_i != '0)) begin
        busy_q[alloc_rd_i]  <= 1'b1;
        owner_q[alloc_rd_i] <= alloc_tag_i;
      end
    end
  end

endmodule
